//--- Bender.yml
package:
  name: control_unit

sources:
  - design/ctrlPkg.sv
  - design/instrClassifier.sv
  - design/phaseSequencer.sv
  - design/controlEncoder.sv
  - design/controlUnit.sv
  - target: test
    files:
      - bench/controlUnitTb.sv

//--- bench/controlUnitTb.sv
// Testbench for controlUnit; replays instruction vectors from the data file and checks controls
module controlUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeoutCycles = 20; // Longest wait for any strobe
	localparam ctrlPkg::wbSelT noWrite = 3'd7; // Vector writes no register

	logic clk;
	logic reset;
	ctrlPkg::instrT instruction;
	logic pcWrite, dMemWrite, irWrite, regWrite, loadRegA, loadRegB;
	logic loadAluOut, loadMdr, pcSrc, pcWriteCond, halted;
	ctrlPkg::muxSelT aluSrcA, aluSrcB;
	ctrlPkg::wbSelT memToReg;
	ctrlPkg::immKindT immKind;
	ctrlPkg::aluFctT aluFct;
	ctrlPkg::shiftTypeT shiftType;
	ctrlPkg::branchTypeT branchType;
	ctrlPkg::loadTypeT loadType;
	ctrlPkg::storeTypeT storeType;

	int valueErrors = 0;
	int otherErrors = 0;
	logic timedOut = 1'b0;

	controlUnit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic reportProblem(input string what);
		$display("Error: %s", what);
		otherErrors++;
	endtask

	task automatic checkStrobe(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0b, actual %0b", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkWbSel(input string name, input ctrlPkg::wbSelT expected,
		input ctrlPkg::wbSelT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkAluFct(input string name, input ctrlPkg::aluFctT expected,
		input ctrlPkg::aluFctT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkShiftType(input string name, input ctrlPkg::shiftTypeT expected,
		input ctrlPkg::shiftTypeT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkLoadType(input string name, input ctrlPkg::loadTypeT expected,
		input ctrlPkg::loadTypeT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkStoreType(input string name, input ctrlPkg::storeTypeT expected,
		input ctrlPkg::storeTypeT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkBranchType(input string name, input ctrlPkg::branchTypeT expected,
		input ctrlPkg::branchTypeT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkMuxSel(input string name, input ctrlPkg::muxSelT expected,
		input ctrlPkg::muxSelT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkImmKind(input string name, input ctrlPkg::immKindT expected,
		input ctrlPkg::immKindT actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	// All strobes idle while reset holds the FSM in fetch
	task automatic expectIdleStrobes();
		checkStrobe("reset pcWrite", 1'b0, pcWrite);
		checkStrobe("reset irWrite", 1'b0, irWrite);
		checkStrobe("reset regWrite", 1'b0, regWrite);
		checkStrobe("reset dMemWrite", 1'b0, dMemWrite);
		checkStrobe("reset loadRegA", 1'b0, loadRegA);
		checkStrobe("reset loadRegB", 1'b0, loadRegB);
		checkStrobe("reset loadMdr", 1'b0, loadMdr);
		checkStrobe("reset loadAluOut", 1'b0, loadAluOut);
		checkStrobe("reset pcWriteCond", 1'b0, pcWriteCond);
		checkStrobe("reset halted", 1'b0, halted);
	endtask

	// PC + 4 is written in the same cycle as the IR load
	task automatic expectFetchControls(input string name);
		checkStrobe({name, " pcWrite"}, 1'b1, pcWrite);
		checkAluFct({name, " aluFct"}, ctrlPkg::aluSum, aluFct);
		checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcAPc, aluSrcA);
		checkMuxSel({name, " aluSrcB"}, ctrlPkg::srcBFour, aluSrcB);
	endtask

	// Operand sources and immediate format of the execute or address cycle
	task automatic expectExecOperands(input string name, input ctrlPkg::opcodeT opcode);
		case (opcode)
			ctrlPkg::opR: begin
				checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcARegA, aluSrcA);
				checkMuxSel({name, " aluSrcB"}, ctrlPkg::srcBRegB, aluSrcB);
				checkImmKind({name, " immKind"}, ctrlPkg::immR, immKind);
			end
			ctrlPkg::opBranch: begin // rs1 compared with rs2
				checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcARegA, aluSrcA);
				checkMuxSel({name, " aluSrcB"}, ctrlPkg::srcBRegB, aluSrcB);
				checkImmKind({name, " immKind"}, ctrlPkg::immSb, immKind);
			end
			ctrlPkg::opImm, ctrlPkg::opLoad, ctrlPkg::opJalr: begin
				checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcARegA, aluSrcA);
				checkMuxSel({name, " aluSrcB"}, ctrlPkg::srcBImm, aluSrcB);
				checkImmKind({name, " immKind"}, ctrlPkg::immI, immKind);
			end
			ctrlPkg::opStore: begin
				checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcARegA, aluSrcA);
				checkMuxSel({name, " aluSrcB"}, ctrlPkg::srcBImm, aluSrcB);
				checkImmKind({name, " immKind"}, ctrlPkg::immS, immKind);
			end
			ctrlPkg::opLui: checkImmKind({name, " immKind"}, ctrlPkg::immU, immKind);
			ctrlPkg::opJal: begin // Target relative to the PC
				checkMuxSel({name, " aluSrcA"}, ctrlPkg::srcAPc, aluSrcA);
				checkImmKind({name, " immKind"}, ctrlPkg::immUj, immKind);
			end
			default: ;
		endcase
	endtask

	task automatic waitIrWrite();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
			seen = irWrite;
		end
		if (!seen) begin
			reportProblem("first irWrite did not appear after reset");
			timedOut = 1'b1;
		end else begin
			expectFetchControls("first fetch");
		end
	endtask

	// Entered on the falling edge of an irWrite cycle and returns on the next one
	task automatic runVector(input string name, input ctrlPkg::instrT word, input int expCycles,
		input ctrlPkg::wbSelT expWb, input ctrlPkg::aluFctT expAlu, input int expType,
		input ctrlPkg::branchTypeT expBranch);
		int cycles;
		logic seenIr, seenHalt, seenMdr, seenStore, anyCond, execCond, linkPcWrite;
		ctrlPkg::wbSelT wbSeen;
		ctrlPkg::aluFctT aluSeen;
		ctrlPkg::shiftTypeT shiftSeen;
		ctrlPkg::branchTypeT branchSeen;
		ctrlPkg::loadTypeT loadSeen;
		ctrlPkg::storeTypeT storeSeen;
		ctrlPkg::opcodeT opcode;
		cycles = 0;
		seenIr = 1'b0;
		seenHalt = 1'b0;
		seenMdr = 1'b0;
		seenStore = 1'b0;
		anyCond = 1'b0;
		execCond = 1'b0;
		linkPcWrite = 1'b0;
		wbSeen = noWrite;
		aluSeen = 'x;
		shiftSeen = 'x;
		branchSeen = 'x;
		loadSeen = 'x;
		storeSeen = 'x;
		opcode = word[6:0];
		instruction = word;
		while (!seenIr && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
			if (irWrite) begin
				seenIr = 1'b1;
				expectFetchControls({name, " next fetch"});
			end else begin
				if (cycles == 1) begin // Decode reads rs1, rs2 and forms the branch target
					checkStrobe({name, " decode loadRegA"}, 1'b1, loadRegA);
					checkStrobe({name, " decode loadRegB"}, 1'b1, loadRegB);
					checkMuxSel({name, " decode aluSrcA"}, ctrlPkg::srcAPc, aluSrcA);
					checkImmKind({name, " decode immKind"}, ctrlPkg::immSb, immKind);
				end
				if (cycles == 2) begin // Execute or address phase
					aluSeen = aluFct;
					shiftSeen = shiftType;
					branchSeen = branchType;
					execCond = pcWriteCond && pcSrc;
					expectExecOperands(name, opcode);
				end
				if (regWrite) begin
					wbSeen = memToReg;
					linkPcWrite = pcWrite;
				end
				if (loadMdr) begin
					seenMdr = 1'b1;
					loadSeen = loadType;
				end
				if (dMemWrite) begin
					seenStore = 1'b1;
					storeSeen = storeType;
				end
				anyCond = anyCond | pcWriteCond;
				seenHalt = seenHalt | halted;
			end
		end
		if (expCycles == 0) begin // Halt vector expects no further irWrite
			if (seenIr) reportProblem({name, ": irWrite appeared after the halt"});
			if (!seenHalt) reportProblem({name, ": halted was never raised"});
		end else if (!seenIr) begin
			reportProblem({name, ": no irWrite within the timeout"});
			timedOut = 1'b1;
		end else begin
			checkCount({name, " cycles"}, expCycles, cycles);
		end
		checkWbSel({name, " memToReg"}, expWb, wbSeen);
		checkAluFct({name, " aluFct"}, expAlu, aluSeen);
		case (opcode)
			ctrlPkg::opLoad: begin
				if (!seenMdr) begin
					reportProblem({name, ": loadMdr was never raised"});
				end else begin
					checkLoadType({name, " loadType"}, ctrlPkg::loadTypeT'(expType),
						loadSeen);
				end
			end
			ctrlPkg::opStore: begin
				if (!seenStore) begin
					reportProblem({name, ": dMemWrite was never raised"});
				end else begin
					checkStoreType({name, " storeType"}, ctrlPkg::storeTypeT'(expType),
						storeSeen);
				end
			end
			default: checkShiftType({name, " shiftType"}, ctrlPkg::shiftTypeT'(expType), shiftSeen);
		endcase
		if (opcode == ctrlPkg::opBranch) begin
			if (!execCond) reportProblem({name, ": pcWriteCond and pcSrc missing in execute"});
			checkBranchType({name, " branchType"}, expBranch, branchSeen);
		end else if (anyCond) begin
			reportProblem({name, ": pcWriteCond raised outside a branch"});
		end
		if (opcode == ctrlPkg::opJal || opcode == ctrlPkg::opJalr) begin
			checkStrobe({name, " pcWrite with link"}, 1'b1, linkPcWrite);
		end
	endtask

	initial begin
		int fd, fields, status, vectors, cycles, wb, alu, typeCode, br;
		logic done;
		string line, name;
		logic [31:0] word;
		vectors = 0;
		done = 1'b0;
		reset = 1'b1;
		instruction = '0;
		#1;
		expectIdleStrobes();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		fd = $fopen("bench/ctrlInputVectors.txt", "r");
		if (fd == 0) begin
			reportProblem("cannot open bench/ctrlInputVectors.txt");
		end else begin
			waitIrWrite();
			while (!done && !timedOut && !$feof(fd)) begin
				status = $fgets(line, fd);
				fields = $sscanf(line, "%s %h %d %d %d %d %d", name, word, cycles, wb, alu,
					typeCode, br);
				if (status > 0 && line.substr(0, 0) != "#" && fields == 7) begin
					runVector(name, word, cycles, ctrlPkg::wbSelT'(wb), ctrlPkg::aluFctT'(alu),
						typeCode, ctrlPkg::branchTypeT'(br));
					vectors++;
					done = (cycles == 0); // Nothing runs after ebreak
				end
			end
			$fclose(fd);
			if (vectors == 0) reportProblem("no vectors were read from the data file");
		end
		$display("Value errors: %0d, other errors: %0d, vectors run: %0d", valueErrors,
			otherErrors, vectors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- bench/ctrlInputVectors.txt
# name word(hex) cycles memToReg aluFct type branchType; cycles 0 marks a halt, memToReg 7 no write
# type is loadType for loads, storeType for stores and shiftType for everything else
add 002081b3 5 0 1 3 0
sub 402081b3 5 0 2 3 0
and 0020f1b3 5 0 3 3 0
addi 00508193 5 0 1 3 0
slt 0020a1b3 4 3 7 3 0
slti 0050a193 4 3 7 3 0
slli 00409193 4 4 0 0 0
srli 0040d193 4 4 0 1 0
srai 4040d193 4 4 0 2 0
lb 00808183 7 1 1 0 0
lh 00809183 7 1 1 1 0
lw 0080a183 7 1 1 2 0
ld 0080b183 7 1 1 3 0
lbu 0080c183 7 1 1 4 0
lhu 0080d183 7 1 1 5 0
lwu 0080e183 7 1 1 6 0
sb 00208423 6 7 1 0 0
sh 00209423 6 7 1 1 0
sw 0020a423 6 7 1 2 0
sd 0020b423 6 7 1 3 0
beq 00208463 4 7 2 3 0
bne 00209463 4 7 2 3 1
blt 0020c463 4 7 2 3 3
bge 0020d463 4 7 2 3 2
lui 123451b7 4 2 0 3 0
jal 010000ef 4 5 1 3 0
jalr 000100e7 4 5 1 3 0
illegal ffffffff 3 7 0 3 0
ebreak 00100073 0 7 0 3 0

//--- design/controlEncoder.sv
// Combinational encoder from the current phase and decoded sub-kinds to datapath controls
module controlEncoder (
	input ctrlPkg::phaseT phase,
	input ctrlPkg::instrClassT instrClass,
	input ctrlPkg::aluFctT aluOp,
	input ctrlPkg::shiftTypeT shiftOp,
	input ctrlPkg::branchTypeT branchOp,
	input ctrlPkg::funct3T memFunct,
	output logic pcWrite,
	output logic dMemWrite,
	output logic irWrite,
	output logic regWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadAluOut,
	output logic loadMdr,
	output logic pcSrc,
	output logic pcWriteCond,
	output logic halted,
	output ctrlPkg::muxSelT aluSrcA,
	output ctrlPkg::muxSelT aluSrcB,
	output ctrlPkg::wbSelT memToReg,
	output ctrlPkg::immKindT immKind,
	output ctrlPkg::aluFctT aluFct,
	output ctrlPkg::shiftTypeT shiftType,
	output ctrlPkg::branchTypeT branchType,
	output ctrlPkg::loadTypeT loadType,
	output ctrlPkg::storeTypeT storeType
);

	logic immForm; // ALU instruction takes its second operand from the immediate

	assign immForm = (memFunct == ctrlPkg::aluFormImm);

	always_comb begin
		pcWrite = 1'b0;
		dMemWrite = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		loadRegA = 1'b0;
		loadRegB = 1'b0;
		loadAluOut = 1'b0;
		loadMdr = 1'b0;
		pcSrc = 1'b0;
		pcWriteCond = 1'b0;
		halted = 1'b0;
		aluSrcA = ctrlPkg::srcAPc;
		aluSrcB = ctrlPkg::srcBRegB;
		memToReg = ctrlPkg::wbAlu;
		immKind = ctrlPkg::immR;
		aluFct = ctrlPkg::aluPass;
		shiftType = ctrlPkg::shiftPass;
		branchType = ctrlPkg::brEq; // Ignored while pcWriteCond is low
		loadType = ctrlPkg::loadLd;
		storeType = ctrlPkg::storeSd;
		case (phase)
			ctrlPkg::phFetch: aluSrcB = ctrlPkg::srcBFour;
			ctrlPkg::phIrLoad: begin
				pcWrite = 1'b1; // PC + 4
				irWrite = 1'b1;
				aluSrcB = ctrlPkg::srcBFour;
				aluFct = ctrlPkg::aluSum;
			end
			ctrlPkg::phDecode: begin
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				loadAluOut = 1'b1; // Branch target kept in AluOut
				aluSrcB = ctrlPkg::srcBImmShift;
				immKind = ctrlPkg::immSb;
				aluFct = ctrlPkg::aluSum;
			end
			ctrlPkg::phExecute: begin
				aluSrcA = ctrlPkg::srcARegA;
				case (instrClass)
					ctrlPkg::clsAluReg: begin
						loadAluOut = 1'b1;
						aluSrcB = immForm ? ctrlPkg::srcBImm : ctrlPkg::srcBRegB;
						immKind = immForm ? ctrlPkg::immI : ctrlPkg::immR;
						aluFct = aluOp;
					end
					ctrlPkg::clsAluDirect: begin
						regWrite = 1'b1; // Compare flag or shifter straight to rd
						aluSrcB = immForm ? ctrlPkg::srcBImm : ctrlPkg::srcBRegB;
						immKind = immForm ? ctrlPkg::immI : ctrlPkg::immR;
						aluFct = aluOp;
						shiftType = shiftOp;
						memToReg = (shiftOp == ctrlPkg::shiftPass) ? ctrlPkg::wbCmp
							: ctrlPkg::wbShift;
					end
					ctrlPkg::clsBranch: begin
						pcWriteCond = 1'b1;
						pcSrc = 1'b1; // Target from AluOut
						immKind = ctrlPkg::immSb;
						aluFct = ctrlPkg::aluSub;
						branchType = branchOp;
					end
					ctrlPkg::clsLui: begin
						regWrite = 1'b1;
						aluSrcB = ctrlPkg::srcBImm;
						immKind = ctrlPkg::immU;
						memToReg = ctrlPkg::wbImm;
					end
					ctrlPkg::clsJal: begin
						pcWrite = 1'b1;
						regWrite = 1'b1; // Link gets the incremented PC
						aluSrcA = ctrlPkg::srcAPc;
						aluSrcB = ctrlPkg::srcBImmShift;
						immKind = ctrlPkg::immUj;
						aluFct = ctrlPkg::aluSum;
						memToReg = ctrlPkg::wbPc;
					end
					ctrlPkg::clsJalr: begin
						pcWrite = 1'b1;
						regWrite = 1'b1;
						aluSrcB = ctrlPkg::srcBImm;
						immKind = ctrlPkg::immI;
						aluFct = ctrlPkg::aluSum;
						memToReg = ctrlPkg::wbPc;
					end
					default: aluSrcA = ctrlPkg::srcARegA;
				endcase
			end
			ctrlPkg::phWriteAlu: begin
				regWrite = 1'b1;
				memToReg = ctrlPkg::wbAlu;
			end
			ctrlPkg::phMemAddr: begin
				loadAluOut = 1'b1; // Effective address
				aluSrcA = ctrlPkg::srcARegA;
				aluSrcB = ctrlPkg::srcBImm;
				aluFct = ctrlPkg::aluSum;
				immKind = (instrClass == ctrlPkg::clsStore) ? ctrlPkg::immS : ctrlPkg::immI;
			end
			ctrlPkg::phMemRequest: begin
				aluSrcA = ctrlPkg::srcARegA;
				aluSrcB = ctrlPkg::srcBImm;
			end
			ctrlPkg::phMdrLoad: begin
				loadMdr = 1'b1;
				loadType = memFunct;
			end
			ctrlPkg::phWriteMem: begin
				regWrite = 1'b1;
				memToReg = ctrlPkg::wbMem;
			end
			ctrlPkg::phStoreWrite: begin
				dMemWrite = 1'b1;
				aluSrcA = ctrlPkg::srcARegA;
				aluSrcB = ctrlPkg::srcBImm;
				storeType = (memFunct > 3'd3) ? ctrlPkg::storeSd : memFunct[1:0];
			end
			ctrlPkg::phHalt: halted = 1'b1;
			default: halted = 1'b0;
		endcase
	end

	// Register file and data memory never write in the same phase
	noWriteClash: assert final (!(regWrite && dMemWrite))
		else $error("regWrite and dMemWrite asserted together");

endmodule

//--- design/controlUnit.sv
// Top of the multicycle RV64 control unit; classifier, phase FSM and control encoder
module controlUnit (
	input logic clk,
	input logic reset,
	input ctrlPkg::instrT instruction, // From the instruction register
	output logic pcWrite,
	output logic dMemWrite,
	output logic irWrite,
	output logic regWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadAluOut,
	output logic loadMdr,
	output logic pcSrc,
	output logic pcWriteCond,
	output logic halted,
	output ctrlPkg::muxSelT aluSrcA,
	output ctrlPkg::muxSelT aluSrcB,
	output ctrlPkg::wbSelT memToReg,
	output ctrlPkg::immKindT immKind,
	output ctrlPkg::aluFctT aluFct,
	output ctrlPkg::shiftTypeT shiftType,
	output ctrlPkg::branchTypeT branchType,
	output ctrlPkg::loadTypeT loadType,
	output ctrlPkg::storeTypeT storeType
);

	ctrlPkg::instrClassT instrClass;
	ctrlPkg::aluFctT aluOp;
	ctrlPkg::shiftTypeT shiftOp;
	ctrlPkg::branchTypeT branchOp;
	ctrlPkg::funct3T memFunct;
	ctrlPkg::phaseT phase;

	instrClassifier uClassifier (
		.instruction(instruction),
		.instrClass(instrClass),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.branchOp(branchOp),
		.memFunct(memFunct)
	);

	phaseSequencer uSequencer (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.phase(phase)
	);

	controlEncoder uEncoder (
		.phase(phase),
		.instrClass(instrClass),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.branchOp(branchOp),
		.memFunct(memFunct),
		.pcWrite(pcWrite),
		.dMemWrite(dMemWrite),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.loadRegA(loadRegA),
		.loadRegB(loadRegB),
		.loadAluOut(loadAluOut),
		.loadMdr(loadMdr),
		.pcSrc(pcSrc),
		.pcWriteCond(pcWriteCond),
		.halted(halted),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.memToReg(memToReg),
		.immKind(immKind),
		.aluFct(aluFct),
		.shiftType(shiftType),
		.branchType(branchType),
		.loadType(loadType),
		.storeType(storeType)
	);

endmodule

//--- design/ctrlPkg.sv
// Shared field types, control codes and FSM enums of the control unit; compile before the RTL
package ctrlPkg;

	typedef logic [31:0] instrT; // Full instruction word
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] funct3T;

	typedef logic [2:0] aluFctT;
	typedef logic [2:0] immKindT; // Sign extender format
	typedef logic [1:0] shiftTypeT;
	typedef logic [1:0] branchTypeT;
	typedef logic [2:0] loadTypeT;
	typedef logic [1:0] storeTypeT;
	typedef logic [1:0] muxSelT; // ALU operand mux select
	typedef logic [2:0] wbSelT; // Register write-back mux select

	localparam opcodeT opR = 7'b0110011;
	localparam opcodeT opImm = 7'b0010011;
	localparam opcodeT opLoad = 7'b0000011;
	localparam opcodeT opStore = 7'b0100011;
	localparam opcodeT opBranch = 7'b1100011;
	localparam opcodeT opJalr = 7'b1100111;
	localparam opcodeT opLui = 7'b0110111;
	localparam opcodeT opJal = 7'b1101111;
	localparam opcodeT opSystem = 7'b1110011;

	localparam aluFctT aluPass = 3'd0;
	localparam aluFctT aluSum = 3'd1;
	localparam aluFctT aluSub = 3'd2;
	localparam aluFctT aluAnd = 3'd3;
	localparam aluFctT aluCmp = 3'd7; // Set-less-than flag

	localparam immKindT immR = 3'd0;
	localparam immKindT immI = 3'd1;
	localparam immKindT immS = 3'd2;
	localparam immKindT immSb = 3'd3;
	localparam immKindT immU = 3'd4;
	localparam immKindT immUj = 3'd5;

	localparam shiftTypeT shiftLeftL = 2'd0;
	localparam shiftTypeT shiftRightL = 2'd1;
	localparam shiftTypeT shiftRightA = 2'd2;
	localparam shiftTypeT shiftPass = 2'd3;

	localparam branchTypeT brEq = 2'd0;
	localparam branchTypeT brNe = 2'd1;
	localparam branchTypeT brGe = 2'd2;
	localparam branchTypeT brLt = 2'd3;

	localparam loadTypeT loadLb = 3'd0; // Same as the load funct3
	localparam loadTypeT loadLd = 3'd3;
	localparam loadTypeT loadLwu = 3'd6; // Highest defined load code

	localparam storeTypeT storeSb = 2'd0; // Same as the store funct3
	localparam storeTypeT storeSd = 2'd3;

	localparam muxSelT srcAPc = 2'd0;
	localparam muxSelT srcARegA = 2'd1;
	localparam muxSelT srcBRegB = 2'd0;
	localparam muxSelT srcBFour = 2'd1; // Constant 4 for PC increment
	localparam muxSelT srcBImm = 2'd2;
	localparam muxSelT srcBImmShift = 2'd3; // Immediate shifted left by one

	localparam wbSelT wbAlu = 3'd0;
	localparam wbSelT wbMem = 3'd1;
	localparam wbSelT wbImm = 3'd2;
	localparam wbSelT wbCmp = 3'd3;
	localparam wbSelT wbShift = 3'd4;
	localparam wbSelT wbPc = 3'd5;

	// ALU classes reuse the memFunct lines to tell register from immediate operands
	localparam funct3T aluFormReg = 3'd0;
	localparam funct3T aluFormImm = 3'd1;

	typedef enum logic [3:0] {
		clsAluReg, clsAluDirect, clsLoad, clsStore, clsBranch,
		clsLui, clsJal, clsJalr, clsBreak, clsIllegal
	} instrClassT;

	typedef enum logic [3:0] {
		phFetch, phIrLoad, phDecode, phExecute, phWriteAlu, phMemAddr,
		phMemRequest, phMdrLoad, phWriteMem, phStoreWrite, phHalt
	} phaseT;

endpackage

//--- design/instrClassifier.sv
// Combinational decoder from the held instruction word to a class and operation sub-kinds
module instrClassifier (
	input ctrlPkg::instrT instruction,
	output ctrlPkg::instrClassT instrClass,
	output ctrlPkg::aluFctT aluOp,
	output ctrlPkg::shiftTypeT shiftOp,
	output ctrlPkg::branchTypeT branchOp,
	output ctrlPkg::funct3T memFunct
);

	ctrlPkg::opcodeT opcode;
	ctrlPkg::funct3T funct3;
	logic [6:0] funct7;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	always_comb begin
		instrClass = ctrlPkg::clsIllegal; // Anything not matched below
		aluOp = ctrlPkg::aluPass;
		shiftOp = ctrlPkg::shiftPass;
		branchOp = ctrlPkg::brEq;
		memFunct = funct3; // Width and sign for loads and stores
		case (opcode)
			ctrlPkg::opR: begin
				memFunct = ctrlPkg::aluFormReg;
				if (funct3 == 3'd0 && funct7 == 7'b0000000) begin
					instrClass = ctrlPkg::clsAluReg;
					aluOp = ctrlPkg::aluSum;
				end else if (funct3 == 3'd0 && funct7 == 7'b0100000) begin
					instrClass = ctrlPkg::clsAluReg;
					aluOp = ctrlPkg::aluSub;
				end else if (funct3 == 3'd7 && funct7 == 7'b0000000) begin
					instrClass = ctrlPkg::clsAluReg;
					aluOp = ctrlPkg::aluAnd;
				end else if (funct3 == 3'd2 && funct7 == 7'b0000000) begin
					instrClass = ctrlPkg::clsAluDirect; // slt
					aluOp = ctrlPkg::aluCmp;
				end
			end
			ctrlPkg::opImm: begin
				memFunct = ctrlPkg::aluFormImm;
				if (funct3 == 3'd0) begin
					instrClass = ctrlPkg::clsAluReg; // addi
					aluOp = ctrlPkg::aluSum;
				end else if (funct3 == 3'd2) begin
					instrClass = ctrlPkg::clsAluDirect; // slti
					aluOp = ctrlPkg::aluCmp;
				end else if (funct3 == 3'd1 && funct7[6:1] == 6'b000000) begin
					instrClass = ctrlPkg::clsAluDirect;
					shiftOp = ctrlPkg::shiftLeftL;
				end else if (funct3 == 3'd5 && funct7[6:1] == 6'b000000) begin
					instrClass = ctrlPkg::clsAluDirect;
					shiftOp = ctrlPkg::shiftRightL;
				end else if (funct3 == 3'd5 && funct7[6:1] == 6'b010000) begin
					instrClass = ctrlPkg::clsAluDirect; // RV64 shamt uses bit 25
					shiftOp = ctrlPkg::shiftRightA;
				end
			end
			ctrlPkg::opLoad: begin
				if (funct3 <= ctrlPkg::loadLwu) instrClass = ctrlPkg::clsLoad;
			end
			ctrlPkg::opStore: instrClass = ctrlPkg::clsStore;
			ctrlPkg::opBranch: begin
				case (funct3)
					3'd0: begin
						instrClass = ctrlPkg::clsBranch;
						branchOp = ctrlPkg::brEq;
					end
					3'd1: begin
						instrClass = ctrlPkg::clsBranch;
						branchOp = ctrlPkg::brNe;
					end
					3'd4: begin
						instrClass = ctrlPkg::clsBranch;
						branchOp = ctrlPkg::brLt;
					end
					3'd5: begin
						instrClass = ctrlPkg::clsBranch;
						branchOp = ctrlPkg::brGe;
					end
					default: instrClass = ctrlPkg::clsIllegal;
				endcase
			end
			ctrlPkg::opJalr: instrClass = ctrlPkg::clsJalr;
			ctrlPkg::opLui: instrClass = ctrlPkg::clsLui;
			ctrlPkg::opJal: instrClass = ctrlPkg::clsJal;
			ctrlPkg::opSystem: begin
				// Only ebreak is supported, immediate 1 with zero registers
				if (instruction[31:20] == 12'd1 && instruction[19:7] == 13'd0) begin
					instrClass = ctrlPkg::clsBreak;
				end
			end
			default: instrClass = ctrlPkg::clsIllegal;
		endcase
	end

endmodule

//--- design/phaseSequencer.sv
// Phase FSM of the multicycle core; one phase per clock, path chosen by the class at decode
module phaseSequencer (
	input logic clk,
	input logic reset,
	input ctrlPkg::instrClassT instrClass,
	output ctrlPkg::phaseT phase
);

	ctrlPkg::phaseT nextPhase;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= ctrlPkg::phFetch;
		end else begin
			phase <= nextPhase;
		end
	end

	// The class stays valid after decode since the IR holds the word
	always_comb begin
		nextPhase = ctrlPkg::phFetch;
		case (phase)
			ctrlPkg::phFetch: nextPhase = ctrlPkg::phIrLoad;
			ctrlPkg::phIrLoad: nextPhase = ctrlPkg::phDecode;
			ctrlPkg::phDecode: begin
				case (instrClass)
					ctrlPkg::clsAluReg,
					ctrlPkg::clsAluDirect,
					ctrlPkg::clsLui,
					ctrlPkg::clsBranch,
					ctrlPkg::clsJal,
					ctrlPkg::clsJalr: nextPhase = ctrlPkg::phExecute;
					ctrlPkg::clsLoad,
					ctrlPkg::clsStore: nextPhase = ctrlPkg::phMemAddr;
					ctrlPkg::clsBreak: nextPhase = ctrlPkg::phHalt;
					default: nextPhase = ctrlPkg::phFetch; // Illegal word is skipped
				endcase
			end
			ctrlPkg::phExecute: begin
				if (instrClass == ctrlPkg::clsAluReg) begin
					nextPhase = ctrlPkg::phWriteAlu; // Result goes through AluOut
				end else begin
					nextPhase = ctrlPkg::phFetch;
				end
			end
			ctrlPkg::phWriteAlu: nextPhase = ctrlPkg::phFetch;
			ctrlPkg::phMemAddr: nextPhase = ctrlPkg::phMemRequest;
			ctrlPkg::phMemRequest: begin
				if (instrClass == ctrlPkg::clsStore) begin
					nextPhase = ctrlPkg::phStoreWrite;
				end else begin
					nextPhase = ctrlPkg::phMdrLoad;
				end
			end
			ctrlPkg::phMdrLoad: nextPhase = ctrlPkg::phWriteMem;
			ctrlPkg::phWriteMem: nextPhase = ctrlPkg::phFetch;
			ctrlPkg::phStoreWrite: nextPhase = ctrlPkg::phFetch;
			ctrlPkg::phHalt: nextPhase = ctrlPkg::phHalt; // Left only through reset
			default: nextPhase = ctrlPkg::phFetch;
		endcase
	end

	// ebreak stops the core for good until the next reset
	haltIsSticky: assert property (
		@(posedge clk) disable iff (reset)
		phase == ctrlPkg::phHalt |=> phase == ctrlPkg::phHalt
	) else $error("Sequencer left the halt phase without reset");

endmodule

//--- filelist.f
design/ctrlPkg.sv
design/instrClassifier.sv
design/phaseSequencer.sv
design/controlEncoder.sv
design/controlUnit.sv
bench/controlUnitTb.sv
